// File: hw/ctlMicroPkg.sv
`default_nettype none

package ctlMicroPkg;

  localparam int dispWidth = 5;
  localparam int specWidth = 5;
  localparam int condWidth = 3;
  localparam int magicWidth = 9;
  localparam int arFieldWidth = 3;

  // Dispatch field
  typedef enum logic [dispWidth-1:0] {
    dispOther  = 5'h00,
    dispNicond = 5'h01,
    dispAread  = 5'h02,
    dispReturn = 5'h03,
    dispMul    = 5'h04,
    dispDiv    = 5'h05,
    dispNorm   = 5'h06,
    dispEaMod  = 5'h07
  } dispCode;

  // Special function field
  typedef enum logic [specWidth-1:0] {
    specNone        = 5'h00,
    specInhCry18    = 5'h01,
    specMqShift     = 5'h02,
    specScmAlt      = 5'h03,
    specClrFpd      = 5'h04,
    specLoadPc      = 5'h05,
    specXcryAr0     = 5'h06,
    specGenCry18    = 5'h07,
    specStackUpdate = 5'h08,
    specArlInd      = 5'h09,
    specFlagCtl     = 5'h0A,
    specSaveFlags   = 5'h0B,
    specSpMemCycle  = 5'h0C,
    specAdLong      = 5'h0D,
    specSbrCall     = 5'h0E
  } specCode;

  // Low three bits of COND
  typedef enum logic [condWidth-1:0] {
    condNone     = 3'b000,
    condArllLoad = 3'b001,
    condArlrLoad = 3'b010,
    condArrLoad  = 3'b011,
    condArClr    = 3'b100,
    condArxClr   = 3'b101,
    condArlInd   = 3'b110,
    condRegCtl   = 3'b111
  } condCode;

endpackage

`default_nettype wire

// File: hw/ctlDiagPkg.sv
`default_nettype none

package ctlDiagPkg;

  localparam int diagDsWidth = 7;
  localparam int ebusWidth = 36;
  localparam int readSlotWidth = 5;
  // First EBUS bit of the readback slot
  localparam int readSlotLow = 24;

  // Function select bits 1 to 3
  typedef enum logic [2:0] {
    grpCtl00 = 3'b000,
    grpCtl01 = 3'b001,
    grpOther = 3'b010,
    grpLd04  = 3'b100,
    grpLd05  = 3'b101,
    grpLd06  = 3'b110,
    grpLd07  = 3'b111
  } diagGroup;

  localparam logic [2:0] diagLoad076 = 3'b110;
  localparam logic [2:0] diagClkEdp077 = 3'b111;

endpackage

`default_nettype wire

// File: hw/ctlDecode.sv
`timescale 1ns/1ps
`default_nettype none

module ctlDecode
  import ctlMicroPkg::*;
(
  input  wire logic                    CTL,
  input  wire logic                    rstN,
  input  wire logic [dispWidth-1:0]    disp,
  input  wire logic [specWidth-1:0]    spec,
  input  wire logic [condWidth-1:0]    cond,
  input  wire logic [0:magicWidth-1]   magic,
  input  wire logic [0:arFieldWidth-1] arField,
  input  wire logic [0:arFieldWidth-1] arxField,
  input  wire logic                    mqField,
  input  wire logic                    adCarry,
  input  wire logic                    condEn,
  input  wire logic                    piCycle,
  input  wire logic                    pcPlus1Inh,
  input  wire logic                    sbrCall,
  input  wire logic                    shortStack,
  input  wire logic                    loadAr,
  input  wire logic                    loadArx,
  input  wire logic                    memArlInd,
  input  wire logic                    ea18,
  input  wire logic                    ea23,
  input  wire logic                    respMem,
  input  wire logic                    arBit0,
  input  wire logic                    arxBit18,
  input  wire logic                    masterReset,
  input  wire logic                    diagArLoad,
  output logic [0:2]                   arlSel,
  output logic [0:1]                   arrSel,
  output logic [0:1]                   arxlSel,
  output logic [0:1]                   arxrSel,
  output logic                         ar00to08Load,
  output logic                         ar09to17Load,
  output logic                         arrLoad,
  output logic                         arxLoad,
  output logic                         ar00to11Clr,
  output logic                         ar12to17Clr,
  output logic                         arrClr,
  output logic                         arxClr,
  output logic                         mqClr,
  output logic [0:1]                   mqSel,
  output logic [0:1]                   mqmSel,
  output logic                         mqmEn,
  output logic                         adLong,
  output logic                         genCry18,
  output logic                         adxCry36,
  output logic                         loadPc,
  output logic                         dispRet,
  output logic                         specCall,
  output logic [0:2]                   regCtl
);

  logic dMul, dDiv, dNorm, dAread, dEaMod, dNicond, dReturn;
  logic cEn, arlInd, regCtl7, regCtl8, arClrD, shortEa, ea36, load1;
  logic resetGrp, mathGrp, pcSet, pcHeld;
  logic [0:2] arlSelD, regCtlD;
  logic [0:1] arrSelD, arxSelD;
  logic mqClrD, arxClrD, arrClrD, ar12ClrD, ar00ClrD, mqmEnD;

  always_comb begin
    dMul = disp == dispMul;
    dDiv = disp == dispDiv;
    dNorm = disp == dispNorm;
    dAread = disp == dispAread;
    dEaMod = disp == dispEaMod;
    dNicond = disp == dispNicond;
    dReturn = disp == dispReturn;
    cEn = condEn;

    arlInd = memArlInd | spec == specArlInd | (cEn && cond == condArlInd);
    regCtlD = magic[0:2] & {3{cEn && cond == condRegCtl}};
    regCtl7 = magic[7] & cEn && cond == condRegCtl;
    regCtl8 = magic[8] & cEn && cond == condRegCtl;

    // Magic bits take over the clears under ARL indirect
    mqClrD = arlInd & magic[2];
    arxClrD = arlInd ? magic[3] : cEn && cond == condArxClr;
    arClrD = arlInd ? magic[4] : cEn && cond == condArClr;
    arrClrD = arlInd ? magic[5] : cEn && cond == condArClr;
    shortEa = dEaMod & arxBit18;
    ar12ClrD = masterReset | ea18 | arClrD | shortEa;
    ar00ClrD = ar12ClrD | ea23;
    ea36 = dAread & ar00ClrD;

    arlSelD[0] = arlInd ? magic[6] : arField[0];
    arlSelD[1] = arlInd ? magic[7] : arField[1] | diagArLoad | ea36;
    arlSelD[2] = arlInd ? magic[8] : arField[2] | diagArLoad | (loadAr & respMem);
    arrSelD[0] = arField[1] | dAread | diagArLoad;
    arrSelD[1] = arField[2] | diagArLoad | (loadAr & respMem);
    arxSelD[0] = arxField[1];
    arxSelD[1] = arxField[2] | (loadArx & respMem);
    load1 = ar00ClrD | (|arlSelD);

    // MQ path vs MQM path, split by mqmEn
    resetGrp = masterReset | regCtl7 | mqClrD;
    mathGrp = mqClrD | regCtl8 | spec == specMqShift | dMul | dDiv;
    mqmEnD = mqField | masterReset;

    pcSet = (spec == specLoadPc | dNicond) & sbrCall;
  end

  always_ff @(posedge CTL) begin
    if (!rstN) begin
      arlSel <= '0;
      arrSel <= '0;
      arxlSel <= '0;
      arxrSel <= '0;
      ar00to08Load <= 1'b0;
      ar09to17Load <= 1'b0;
      arrLoad <= 1'b0;
      arxLoad <= 1'b0;
      ar00to11Clr <= 1'b0;
      ar12to17Clr <= 1'b0;
      arrClr <= 1'b0;
      arxClr <= 1'b0;
      mqClr <= 1'b0;
      mqSel <= '0;
      mqmSel <= '0;
      mqmEn <= 1'b0;
      adLong <= 1'b0;
      genCry18 <= 1'b0;
      adxCry36 <= 1'b0;
      loadPc <= 1'b0;
      pcHeld <= 1'b0;
      dispRet <= 1'b0;
      specCall <= 1'b0;
      regCtl <= '0;
    end else begin
      arlSel <= arlSelD;
      arrSel <= arrSelD;
      arxlSel <= arxSelD;
      arxrSel <= arxSelD;
      ar00to08Load <= (cEn && cond == condArllLoad) | regCtlD[0] | load1 | (magic[0] & arlInd);
      ar09to17Load <= (cEn && cond == condArlrLoad) | regCtlD[1] | load1;
      arrLoad <= (cEn && cond == condArrLoad) | regCtlD[2] | arField[0] | (|arrSelD) | arrClrD;
      arxLoad <= arxField[0] | (|arxSelD) | arxClrD | masterReset;
      ar00to11Clr <= ar00ClrD;
      ar12to17Clr <= ar12ClrD;
      arrClr <= arrClrD;
      arxClr <= arxClrD;
      mqClr <= mqClrD;
      mqSel <= {resetGrp, mathGrp} & {2{~mqmEnD}};
      mqmSel <= {resetGrp, mathGrp} & {2{mqmEnD}};
      mqmEn <= mqmEnD;
      adLong <= dMul | dDiv | dNorm | spec == specAdLong | spec == specMqShift;
      genCry18 <= spec == specGenCry18 | (spec == specStackUpdate & shortStack);
      adxCry36 <= ~(pcPlus1Inh & spec == specSaveFlags) &
                  (adCarry ^ (arBit0 & spec == specXcryAr0));
      // Request held until a PI cycle takes it
      loadPc <= piCycle & (pcSet | pcHeld);
      pcHeld <= (pcSet | pcHeld) & ~piCycle;
      dispRet <= sbrCall & dReturn;
      specCall <= ~sbrCall & (arlInd ? magic[0] : spec == specSbrCall);
      regCtl <= regCtlD;
    end
  end

endmodule

`default_nettype wire

// File: hw/diagFuncDecode.sv
`timescale 1ns/1ps
`default_nettype none

module diagFuncDecode
  import ctlMicroPkg::*;
  import ctlDiagPkg::*;
(
  input  wire logic                   CTL,
  input  wire logic                   rstN,
  input  wire logic [0:diagDsWidth-1] ds,
  input  wire logic                   diagStrobe,
  input  wire logic                   condDiagFunc,
  input  wire logic [0:magicWidth-1]  magic,
  input  wire logic                   diag4,
  output logic [0:diagDsWidth-1]      dsEff,
  output logic                        diagReadEn,
  output logic                        load076,
  output logic                        diagClkEdp,
  output logic                        diagArLoad
);

  logic consoleControl;
  logic readStrobe;
  logic load07x;

  always_comb begin
    consoleControl = ds[0] | ds[1];
    readStrobe = consoleControl ? diagStrobe : condDiagFunc;
    dsEff = consoleControl ? ds : magic[2:8];

    // Loads only come from the console bus
    load07x = ~ds[0] & diagStrobe && ds[1:3] == grpLd07;
    load076 = load07x && ds[4:6] == diagLoad076;

    // Read 10x shares the 000 group code
    diagReadEn = dsEff[0] & readStrobe && dsEff[1:3] == grpCtl00;
    diagArLoad = dsEff[0] & (&dsEff[1:3]) & diag4 & (&dsEff[4:6]);
  end

  // EDP clock pulse one cycle after function 077
  always_ff @(posedge CTL) begin
    if (!rstN) begin
      diagClkEdp <= 1'b0;
    end else begin
      diagClkEdp <= load07x && ds[4:6] == diagClkEdp077;
    end
  end

endmodule

`default_nettype wire

// File: hw/diagRegister.sv
`timescale 1ns/1ps
`default_nettype none

module diagRegister
  import ctlDiagPkg::*;
(
  input  wire logic                 CTL,
  input  wire logic                 rstN,
  input  wire logic                 load076,
  input  wire logic [0:ebusWidth-1] ebusDataIn,
  output logic                      memReset,
  output logic                      channelClkStop,
  output logic                      ldEbusReg,
  output logic                      forceExtend,
  output logic                      diag4
);

  // Bits 24 to 28 in order
  always_ff @(posedge CTL) begin
    if (!rstN) begin
      {memReset, channelClkStop, ldEbusReg, forceExtend, diag4} <= '0;
    end else if (load076) begin
      {memReset, channelClkStop, ldEbusReg, forceExtend, diag4} <=
          ebusDataIn[readSlotLow +: readSlotWidth];
    end
  end

endmodule

`default_nettype wire

// File: hw/ebusReadMux.sv
`timescale 1ns/1ps
`default_nettype none

module ebusReadMux
  import ctlDiagPkg::*;
(
  input  wire logic                   diagReadEn,
  input  wire logic [0:diagDsWidth-1] dsEff,
  input  wire logic [0:2]             arlSel,
  input  wire logic [0:1]             arrSel,
  input  wire logic [0:1]             arxlSel,
  input  wire logic [0:1]             arxrSel,
  input  wire logic                   ar00to08Load,
  input  wire logic                   ar09to17Load,
  input  wire logic                   arrLoad,
  input  wire logic                   arxLoad,
  input  wire logic                   ar00to11Clr,
  input  wire logic                   ar12to17Clr,
  input  wire logic                   arrClr,
  input  wire logic                   arxClr,
  input  wire logic                   mqClr,
  input  wire logic [0:1]             mqSel,
  input  wire logic [0:1]             mqmSel,
  input  wire logic                   mqmEn,
  input  wire logic                   adLong,
  input  wire logic                   genCry18,
  input  wire logic                   adxCry36,
  input  wire logic                   loadPc,
  input  wire logic                   dispRet,
  input  wire logic                   specCall,
  input  wire logic [0:2]             regCtl,
  input  wire logic                   memReset,
  input  wire logic                   ldEbusReg,
  output logic                        ebusDriving,
  output logic [0:readSlotWidth-1]    ebusDataOut
);

  always_comb begin
    ebusDriving = diagReadEn;
    ebusDataOut = '0;
    if (diagReadEn) begin
      unique case (dsEff[4:6])
        3'd0: ebusDataOut = {regCtl[0], mqClr, arlSel[1], arrLoad, ar00to08Load};
        3'd1: ebusDataOut = {regCtl[1], arxClr, arlSel[0], arrLoad, ar09to17Load};
        3'd2: ebusDataOut = {genCry18, regCtl[2], arrSel[1], mqmSel[1], arxLoad};
        3'd3: ebusDataOut = {adxCry36, dispRet, arrSel[0], mqmSel[0], arlSel[2]};
        3'd4: ebusDataOut = {arrClr, loadPc, arxlSel[1], mqSel[1], ar00to11Clr};
        3'd5: ebusDataOut = {arxClr, adxCry36, arxlSel[0], mqSel[0], ar12to17Clr};
        3'd6: ebusDataOut = {adLong, adxCry36, arxrSel[1], mqmEn, arrClr};
        // Carry-18 control sits beside the stored diag bits
        3'd7: ebusDataOut = {genCry18, memReset, arxrSel[0], ldEbusReg, specCall};
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/ctlBoard.sv
`timescale 1ns/1ps
`default_nettype none

module ctlBoard
  import ctlMicroPkg::*;
  import ctlDiagPkg::*;
(
  input  wire logic                    CTL,
  input  wire logic                    rstN,
  input  wire logic [dispWidth-1:0]    disp,
  input  wire logic [specWidth-1:0]    spec,
  input  wire logic [condWidth-1:0]    cond,
  input  wire logic [0:magicWidth-1]   magic,
  input  wire logic [0:arFieldWidth-1] arField,
  input  wire logic [0:arFieldWidth-1] arxField,
  input  wire logic                    mqField,
  input  wire logic                    adCarry,
  input  wire logic                    condEn,
  input  wire logic                    piCycle,
  input  wire logic                    pcPlus1Inh,
  input  wire logic                    sbrCall,
  input  wire logic                    shortStack,
  input  wire logic                    loadAr,
  input  wire logic                    loadArx,
  input  wire logic                    memArlInd,
  input  wire logic                    ea18,
  input  wire logic                    ea23,
  input  wire logic                    respMem,
  input  wire logic                    arBit0,
  input  wire logic                    arxBit18,
  input  wire logic                    masterReset,
  input  wire logic [0:diagDsWidth-1]  ds,
  input  wire logic                    diagStrobe,
  input  wire logic [0:ebusWidth-1]    ebusDataIn,
  input  wire logic                    condDiagFunc,
  output logic                         channelClkStop,
  output logic                         forceExtend,
  output logic                         diagClkEdp,
  output logic                         ebusDriving,
  output logic [0:readSlotWidth-1]     ebusDataOut
);

  logic [0:2] arlSel, regCtl;
  logic [0:1] arrSel, arxlSel, arxrSel, mqSel, mqmSel;
  logic ar00to08Load, ar09to17Load, arrLoad, arxLoad;
  logic ar00to11Clr, ar12to17Clr, arrClr, arxClr, mqClr, mqmEn;
  logic adLong, genCry18, adxCry36, loadPc, dispRet, specCall;
  logic [0:diagDsWidth-1] dsEff;
  logic diagReadEn, load076, diagArLoad, memReset, ldEbusReg, diag4;

  ctlDecode uDecode (
    .CTL, .rstN, .disp, .spec, .cond, .magic, .arField, .arxField, .mqField,
    .adCarry, .condEn, .piCycle, .pcPlus1Inh, .sbrCall, .shortStack, .loadAr,
    .loadArx, .memArlInd, .ea18, .ea23, .respMem, .arBit0, .arxBit18,
    .masterReset, .diagArLoad,
    .arlSel, .arrSel, .arxlSel, .arxrSel, .ar00to08Load, .ar09to17Load,
    .arrLoad, .arxLoad, .ar00to11Clr, .ar12to17Clr, .arrClr, .arxClr, .mqClr,
    .mqSel, .mqmSel, .mqmEn, .adLong, .genCry18, .adxCry36, .loadPc, .dispRet,
    .specCall, .regCtl
  );

  diagFuncDecode uFunc (
    .CTL, .rstN, .ds, .diagStrobe, .condDiagFunc, .magic, .diag4,
    .dsEff, .diagReadEn, .load076, .diagClkEdp, .diagArLoad
  );

  diagRegister uDiagReg (
    .CTL, .rstN, .load076, .ebusDataIn,
    .memReset, .channelClkStop, .ldEbusReg, .forceExtend, .diag4
  );

  ebusReadMux uReadMux (
    .diagReadEn, .dsEff, .arlSel, .arrSel, .arxlSel, .arxrSel, .ar00to08Load,
    .ar09to17Load, .arrLoad, .arxLoad, .ar00to11Clr, .ar12to17Clr, .arrClr,
    .arxClr, .mqClr, .mqSel, .mqmSel, .mqmEn, .adLong, .genCry18, .adxCry36,
    .loadPc, .dispRet, .specCall, .regCtl, .memReset, .ldEbusReg,
    .ebusDriving, .ebusDataOut
  );

endmodule

`default_nettype wire

// File: test/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
  output logic CTL,
  output logic rstN
);

  // 20 ns period
  initial begin
    CTL = 1'b0;
    forever #10 CTL = ~CTL;
  end

  initial begin
    rstN = 1'b0;
    repeat (16) @(posedge CTL);
    rstN <= 1'b1;
  end

endmodule

`default_nettype wire

// File: test/ctlBoard_props.sv
`timescale 1ns/1ps
`default_nettype none

module ctlBoard_props
  import ctlMicroPkg::*;
  import ctlDiagPkg::*;
(
  input wire logic                    CTL,
  input wire logic                    rstN,
  input wire logic [dispWidth-1:0]    disp,
  input wire logic [specWidth-1:0]    spec,
  input wire logic [condWidth-1:0]    cond,
  input wire logic [0:magicWidth-1]   magic,
  input wire logic [0:arFieldWidth-1] arField,
  input wire logic                    condEn,
  input wire logic                    shortStack,
  input wire logic                    loadAr,
  input wire logic                    memArlInd,
  input wire logic                    masterReset,
  input wire logic [0:diagDsWidth-1]  ds,
  input wire logic                    diagStrobe,
  input wire logic                    condDiagFunc,
  input wire logic [0:ebusWidth-1]    ebusDataIn,
  input wire logic [0:31]             ctlOuts,
  input wire logic [0:4]              diagBits,
  input wire logic [0:2]              arlSel,
  input wire logic                    arxClr,
  input wire logic                    ar00to11Clr,
  input wire logic                    ar12to17Clr,
  input wire logic                    adLong,
  input wire logic                    genCry18,
  input wire logic [0:1]              mqSel,
  input wire logic [0:1]              mqmSel,
  input wire logic                    channelClkStop,
  input wire logic                    forceExtend,
  input wire logic                    diagClkEdp,
  input wire logic                    ebusDriving,
  input wire logic [0:readSlotWidth-1] ebusDataOut
);

  logic longUop;
  logic carry18Req;
  logic arlIndReq;
  logic plainArl;
  logic loadReq;
  logic edpReq;
  logic readStrobe;
  logic readHit;
  logic diagArReq;
  logic [0:diagDsWidth-1] readSel;
  logic expMemReset;
  logic expLdEbusReg;
  logic expDiag4;
  int failCount = 0;

  always_comb begin
    longUop = disp == dispMul || disp == dispDiv || disp == dispNorm ||
              spec == specAdLong || spec == specMqShift;
    carry18Req = spec == specGenCry18 || (spec == specStackUpdate && shortStack);
    arlIndReq = memArlInd || spec == specArlInd || (condEn && cond == condArlInd);
    // Console owns the bus when either top select bit is set
    readSel = (ds[0] | ds[1]) ? ds : magic[2:8];
    readStrobe = (ds[0] | ds[1]) ? diagStrobe : condDiagFunc;
    readHit = readStrobe && readSel[0] && readSel[1:3] == 3'b000;
    loadReq = diagStrobe && ds == 7'o076;
    edpReq = diagStrobe && ds == 7'o077;
    diagArReq = readSel[0] && (&readSel[1:3]) && expDiag4 && (&readSel[4:6]);
    plainArl = !arlIndReq && !loadAr && disp != dispAread && !diagArReq;
  end

  // Diag register contents as loaded by function 076
  always_ff @(posedge CTL) begin
    if (!rstN) begin
      expMemReset <= 1'b0;
      expLdEbusReg <= 1'b0;
      expDiag4 <= 1'b0;
    end else if (loadReq) begin
      expMemReset <= ebusDataIn[24];
      expLdEbusReg <= ebusDataIn[26];
      expDiag4 <= ebusDataIn[28];
    end
  end

  resetClear: assert property (@(posedge CTL)
    !rstN |=> (ctlOuts == '0 && diagBits == '0 && !ebusDriving))
    else begin
      failCount++;
      $error("Mismatch at %0t: outputs not low under reset", $time);
    end

  longAdd: assert property (@(posedge CTL) disable iff (!rstN) longUop |=> adLong)
    else begin
      failCount++;
      $error("Mismatch at %0t: adLong low after long dispatch or special", $time);
    end

  carry18: assert property (@(posedge CTL) disable iff (!rstN)
    1'b1 |=> genCry18 == $past(carry18Req))
    else begin
      failCount++;
      $error("Mismatch at %0t: genCry18 differs from its special", $time);
    end

  mqExclusive: assert property (@(posedge CTL) disable iff (!rstN)
    !((|mqSel) && (|mqmSel)))
    else begin
      failCount++;
      $error("Mismatch at %0t: MQ and MQM selects both active", $time);
    end

  arlIndirect: assert property (@(posedge CTL) disable iff (!rstN)
    arlIndReq |=> arlSel == $past(magic[6:8]) && arxClr == $past(magic[3]))
    else begin
      failCount++;
      $error("Mismatch at %0t: ARL selects or ARX clear not from magic", $time);
    end

  arlField: assert property (@(posedge CTL) disable iff (!rstN)
    plainArl |=> arlSel == $past(arField))
    else begin
      failCount++;
      $error("Mismatch at %0t: ARL selects do not follow the AR field", $time);
    end

  diagLoad: assert property (@(posedge CTL) disable iff (!rstN)
    loadReq |=> channelClkStop == $past(ebusDataIn[25]) &&
                forceExtend == $past(ebusDataIn[27]))
    else begin
      failCount++;
      $error("Mismatch at %0t: diag register not loaded by 076", $time);
    end

  edpClock: assert property (@(posedge CTL) disable iff (!rstN)
    1'b1 |=> diagClkEdp == $past(edpReq))
    else begin
      failCount++;
      $error("Mismatch at %0t: EDP clock pulse differs from function 077", $time);
    end

  readDrive: assert property (@(posedge CTL) disable iff (!rstN) readHit |-> ebusDriving)
    else begin
      failCount++;
      $error("Mismatch at %0t: EBUS not driven on read 10x", $time);
    end

  readSlot7: assert property (@(posedge CTL) disable iff (!rstN)
    readHit && readSel[4:6] == 3'd7 |->
      ebusDataOut[1] == expMemReset && ebusDataOut[3] == expLdEbusReg)
    else begin
      failCount++;
      $error("Mismatch at %0t: slot 7 readback differs from diag register", $time);
    end

  busIdle: assert property (@(posedge CTL) disable iff (!rstN)
    !readStrobe |-> !ebusDriving && ebusDataOut == '0)
    else begin
      failCount++;
      $error("Mismatch at %0t: EBUS active without a read strobe", $time);
    end

  clrNesting: assert property (@(posedge CTL) disable iff (!rstN)
    ar12to17Clr |-> ar00to11Clr)
    else begin
      failCount++;
      $error("Mismatch at %0t: AR 12-17 clear without AR 00-11 clear", $time);
    end

  resetClears: assert property (@(posedge CTL) disable iff (!rstN)
    masterReset |=> ar12to17Clr && ar00to11Clr)
    else begin
      failCount++;
      $error("Mismatch at %0t: masterReset did not force the AR clears", $time);
    end

endmodule

`default_nettype wire

// File: test/ctlBoard_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ctlBoard_tb
  import ctlMicroPkg::*;
  import ctlDiagPkg::*;
();

  localparam int resetCycles = 18;
  localparam int decodeCycles = 14;
  localparam int arlCycles = 17;
  localparam int loadCycles = 7;
  localparam int readCycles = 18;
  localparam int randomCycles = 202;
  localparam int timeoutCycles = resetCycles + decodeCycles + arlCycles + loadCycles +
                                 readCycles + randomCycles + 100;

  logic CTL;
  logic rstN;
  logic [dispWidth-1:0] disp;
  logic [specWidth-1:0] spec;
  logic [condWidth-1:0] cond;
  logic [0:magicWidth-1] magic;
  logic [0:arFieldWidth-1] arField;
  logic [0:arFieldWidth-1] arxField;
  logic mqField;
  logic adCarry;
  logic condEn;
  logic piCycle;
  logic pcPlus1Inh;
  logic sbrCall;
  logic shortStack;
  logic loadAr;
  logic loadArx;
  logic memArlInd;
  logic ea18;
  logic ea23;
  logic respMem;
  logic arBit0;
  logic arxBit18;
  logic masterReset;
  logic [0:diagDsWidth-1] ds;
  logic diagStrobe;
  logic [0:ebusWidth-1] ebusDataIn;
  logic condDiagFunc;
  logic channelClkStop;
  logic forceExtend;
  logic diagClkEdp;
  logic ebusDriving;
  logic [0:readSlotWidth-1] ebusDataOut;

  integer seed;
  logic [31:0] r;
  logic [31:0] s;
  int cycleCount;
  int testsRun = 0;
  int testsFailed = 0;
  int failsBefore = 0;

  tbClock clockGen (
    .CTL(CTL),
    .rstN(rstN)
  );

  ctlBoard UUT (.*);

  bind ctlBoard ctlBoard_props propsChk (
    .CTL(CTL), .rstN(rstN), .disp(disp), .spec(spec), .cond(cond), .magic(magic),
    .arField(arField), .condEn(condEn), .shortStack(shortStack), .loadAr(loadAr),
    .memArlInd(memArlInd), .masterReset(masterReset), .ds(ds), .diagStrobe(diagStrobe),
    .condDiagFunc(condDiagFunc), .ebusDataIn(ebusDataIn),
    .ctlOuts({arlSel, arrSel, arxlSel, arxrSel, ar00to08Load, ar09to17Load, arrLoad,
              arxLoad, ar00to11Clr, ar12to17Clr, arrClr, arxClr, mqClr, mqSel, mqmSel,
              mqmEn, adLong, genCry18, adxCry36, loadPc, dispRet, specCall, regCtl}),
    .diagBits({memReset, channelClkStop, ldEbusReg, forceExtend, diag4}),
    .arlSel(arlSel), .arxClr(arxClr), .ar00to11Clr(ar00to11Clr),
    .ar12to17Clr(ar12to17Clr), .adLong(adLong), .genCry18(genCry18), .mqSel(mqSel),
    .mqmSel(mqmSel), .channelClkStop(channelClkStop), .forceExtend(forceExtend),
    .diagClkEdp(diagClkEdp), .ebusDriving(ebusDriving), .ebusDataOut(ebusDataOut)
  );

  task automatic driveIdle();
    {disp, spec, cond, magic, arField, arxField, mqField, adCarry} <= '0;
    {condEn, piCycle, pcPlus1Inh, sbrCall, shortStack, loadAr, loadArx} <= '0;
    {memArlInd, ea18, ea23, respMem, arBit0, arxBit18, masterReset} <= '0;
    ds <= '0;
    diagStrobe <= 1'b0;
    ebusDataIn <= '0;
    condDiagFunc <= 1'b0;
  endtask

  // New cycle with one microword and idle other inputs
  task automatic driveUop(input logic [dispWidth-1:0] d, input logic [specWidth-1:0] sp,
                          input logic [condWidth-1:0] c, input logic [0:magicWidth-1] m);
    @(posedge CTL);
    driveIdle();
    disp <= d;
    spec <= sp;
    cond <= c;
    magic <= m;
  endtask

  task automatic strobeDiag(input logic [0:diagDsWidth-1] sel,
                            input logic [0:ebusWidth-1] data);
    @(posedge CTL);
    driveIdle();
    ds <= sel;
    diagStrobe <= 1'b1;
    ebusDataIn <= data;
  endtask

  task automatic driveRandomUop();
    r = $random(seed);
    s = $random(seed);
    @(posedge CTL);
    driveIdle();
    {disp, spec, cond, magic, arField, arxField} <= r[27:0];
    {mqField, adCarry, condEn, masterReset} <= r[31:28];
    {piCycle, pcPlus1Inh, sbrCall, shortStack, loadAr, loadArx} <= s[5:0];
    {memArlInd, ea18, ea23, respMem, arBit0, arxBit18} <= s[11:6];
  endtask

  task automatic reportTest(input string name);
    int fails;
    @(posedge CTL);
    driveIdle();
    @(posedge CTL);
    // Checks of the last edge have all run by the falling edge
    @(negedge CTL);
    fails = UUT.propsChk.failCount - failsBefore;
    failsBefore = UUT.propsChk.failCount;
    testsRun++;
    if (fails > 0) begin
      testsFailed++;
    end
    $display("Test %0d %s: %s (%0d assertion failures)", testsRun, name,
             fails == 0 ? "ok" : "failed", fails);
  endtask

  initial begin
    cycleCount = 0;
    while (cycleCount < timeoutCycles) begin
      @(posedge CTL);
      cycleCount++;
    end
    $display("Timeout: tests still running after %0d cycles", cycleCount);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    seed = 32'h48d8;
    driveIdle();
    while (!rstN) begin
      @(posedge CTL);
    end
    reportTest("reset");

    driveUop(dispMul, specNone, condNone, '0);
    driveUop(dispDiv, specNone, condNone, '0);
    driveUop(dispNorm, specNone, condNone, '0);
    driveUop(dispOther, specAdLong, condNone, '0);
    driveUop(dispOther, specMqShift, condNone, '0);
    driveUop(dispOther, specGenCry18, condNone, '0);
    driveUop(dispOther, specStackUpdate, condNone, '0);
    shortStack <= 1'b1;
    driveUop(dispOther, specStackUpdate, condNone, '0);
    driveUop(dispMul, specNone, condRegCtl, 9'h1ff);
    condEn <= 1'b1;
    mqField <= 1'b1;
    driveUop(dispOther, specNone, condNone, '0);
    masterReset <= 1'b1;
    reportTest("dispatch and special decode");

    repeat (4) begin
      r = $random(seed);
      driveUop(dispOther, specNone, condArlInd, r[8:0]);
      condEn <= 1'b1;
      arField <= r[11:9];
    end
    repeat (4) begin
      r = $random(seed);
      driveUop(dispOther, specNone, condNone, r[8:0]);
      memArlInd <= 1'b1;
      arField <= r[11:9];
    end
    r = $random(seed);
    driveUop(dispOther, specArlInd, condNone, r[8:0]);
    repeat (6) begin
      r = $random(seed);
      driveUop(dispOther, specNone, condNone, r[8:0]);
      arField <= r[11:9];
    end
    reportTest("ARL indirect");

    repeat (3) begin
      r = $random(seed);
      strobeDiag(7'o076, {r[3:0], r});
    end
    strobeDiag(7'o077, '0);
    reportTest("diagnostic load");

    // memReset and ldEbusReg set by bits 24 and 26
    strobeDiag(7'o076, 36'h000000A00);
    for (int slot = 0; slot < 8; slot++) begin
      strobeDiag(7'o100 | 7'(slot), '0);
    end
    driveUop(dispOther, specNone, condNone, {2'b00, 7'o107});
    condDiagFunc <= 1'b1;
    driveUop(dispOther, specNone, condNone, {2'b00, 7'o107});
    strobeDiag(7'o076, '0);
    strobeDiag(7'o107, '0);
    reportTest("readback");

    repeat (200) begin
      driveRandomUop();
    end
    reportTest("random microwords");

    $display("Tests run: %0d, failed: %0d, assertion failures: %0d", testsRun,
             testsFailed, UUT.propsChk.failCount);
    if (testsFailed == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
hw/ctlMicroPkg.sv
hw/ctlDiagPkg.sv
hw/ctlDecode.sv
hw/diagFuncDecode.sv
hw/diagRegister.sv
hw/ebusReadMux.sv
hw/ctlBoard.sv
test/tbClock.sv
test/ctlBoard_props.sv
test/ctlBoard_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module ctlBoard_tb -f src.f -o simv
./obj_dir/simv +verilator+error+limit+1000 | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi
echo "Simulation finished cleanly"
